// ==== files.f ====
src/csr_bus_pkg.sv
src/csr_map_pkg.sv
src/csr_wide_if.sv
src/csr_upsizer.sv
src/csr_decode.sv
src/csr_reg_bank.sv
src/csr_resp.sv
src/csr_upsize_top.sv
bench/tb_clock.sv
bench/csr_upsize_assertions.sv
bench/tb_csr_upsize.sv

// ==== Bender.yml ====
package:
  name: csr_upsize

sources:
  - src/csr_bus_pkg.sv
  - src/csr_map_pkg.sv
  - src/csr_wide_if.sv
  - src/csr_upsizer.sv
  - src/csr_decode.sv
  - src/csr_reg_bank.sv
  - src/csr_resp.sv
  - src/csr_upsize_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/csr_upsize_assertions.sv
      - bench/tb_csr_upsize.sv

// ==== bench/tb_csr_upsize.sv ====
// Table-driven testbench for the CSR upsizer subsystem.
// Stimulus table, LFSR back-pressure on responses, value checks,
// response counting and a cycle-count timeout.
module tb_csr_upsize;

  localparam int ENTRY_COUNT     = 22;
  localparam int CYCLES_PER_TEST = 40;
  localparam int TIMEOUT_CYCLES  = ENTRY_COUNT * CYCLES_PER_TEST;

  localparam csr_bus_pkg::csr_cmd_t RD    = csr_bus_pkg::CSR_READ;
  localparam csr_bus_pkg::csr_cmd_t WR    = csr_bus_pkg::CSR_WRITE;
  localparam csr_bus_pkg::csr_cmd_t WR_NP = csr_bus_pkg::CSR_WRITE_NP;

  typedef struct {
    string                       name;
    csr_bus_pkg::csr_cmd_t       cmd;
    csr_bus_pkg::csr_addr_t      addr;
    csr_bus_pkg::narrow_data_t   data;
    csr_bus_pkg::narrow_byteen_t byteen;
    logic                        has_resp;
    csr_bus_pkg::narrow_data_t   exp_data;
    logic                        exp_error;
  } vector_t;

  logic                        clk;
  logic                        rst_n;
  logic                        cmd_valid;
  logic                        cmd_accept;
  csr_bus_pkg::csr_cmd_t       cmd;
  csr_bus_pkg::csr_addr_t      addr;
  csr_bus_pkg::narrow_data_t   data;
  csr_bus_pkg::narrow_byteen_t byteen;
  logic                        resp_valid;
  logic                        resp_accept;
  csr_bus_pkg::narrow_data_t   resp_data;
  logic                        resp_error;

  vector_t     vectors [ENTRY_COUNT];
  int          fill_count     = 0;
  int          error_count    = 0;
  int          resp_count     = 0;
  int          expected_resps = 0;
  int          cycle_count    = 0;
  logic [31:0] lfsr_state     = 32'h8d87;

  tb_clock u_clock (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  csr_upsize_top uut (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_cmd_valid   (cmd_valid),
    .o_cmd_accept  (cmd_accept),
    .i_cmd         (cmd),
    .i_addr        (addr),
    .i_data        (data),
    .i_byteen      (byteen),
    .o_resp_valid  (resp_valid),
    .i_resp_accept (resp_accept),
    .o_resp_data   (resp_data),
    .o_resp_error  (resp_error)
  );

  // Taps 32, 22, 2, 1.
  function automatic logic next_random_bit();
    logic feedback;
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic add_entry(input string name, input csr_bus_pkg::csr_cmd_t c,
                           input csr_bus_pkg::csr_addr_t a, input logic [31:0] d,
                           input logic [3:0] be, input logic has_resp,
                           input logic [31:0] exp_data, input logic exp_error);
    vectors[fill_count] = '{name, c, a, d, be, has_resp, exp_data, exp_error};
    fill_count++;
  endtask

  // One command, then its response under random back-pressure.
  task automatic apply_entry(input vector_t v);
    logic resp_done;
    logic first_cycle;
    cmd_valid = 1'b1;
    cmd       = v.cmd;
    addr      = v.addr;
    data      = v.data;
    byteen    = v.byteen;
    @(negedge clk);
    while (!cmd_accept) begin
      @(negedge clk);
    end
    @(posedge clk);   // Transfer edge.
    #1;
    cmd_valid = 1'b0;
    // Flipped payload points the live lane away from the stored one.
    addr        = ~v.addr;
    data        = ~v.data;
    byteen      = ~v.byteen;
    resp_done   = !v.has_resp;
    first_cycle = 1'b1;
    while (!resp_done) begin
      resp_accept = next_random_bit();
      @(negedge clk);
      check_value({v.name, " accept blocked"}, 1'b0, cmd_accept);
      if (first_cycle) begin
        check_value({v.name, " resp valid"}, 1'b1, resp_valid);   // One cycle latency.
      end
      first_cycle = 1'b0;
      if (resp_valid) begin
        check_value({v.name, " data"}, v.exp_data, resp_data);
        check_value({v.name, " error"}, v.exp_error, resp_error);
        resp_done = resp_accept;
      end
      @(posedge clk);
      #1;
    end
    resp_accept = 1'b1;   // Idle accept lets a stray response show in the count.
  endtask

  always @(negedge clk) begin
    if (rst_n && resp_valid && resp_accept) begin
      resp_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    cmd_valid   = 1'b0;
    cmd         = RD;
    addr        = '0;
    data        = '0;
    byteen      = '0;
    resp_accept = 1'b1;

    add_entry("np_wr_lo",     WR_NP, 16'h0008, 32'h1111_2222, 4'hf, 1, 32'h0000_0000, 0);
    add_entry("np_wr_hi",     WR_NP, 16'h000C, 32'h3333_4444, 4'hf, 1, 32'h0000_0000, 0);
    add_entry("rd_lo",        RD,    16'h0008, 32'h0,         4'hf, 1, 32'h1111_2222, 0);
    add_entry("rd_hi",        RD,    16'h000C, 32'h0,         4'hf, 1, 32'h3333_4444, 0);
    add_entry("np_wr_r2_hi",  WR_NP, 16'h0014, 32'hA5A5_A5A5, 4'hf, 1, 32'h0000_0000, 0);
    add_entry("rd_r2_lo",     RD,    16'h0010, 32'h0,         4'hf, 1, 32'h0000_0000, 0);
    add_entry("rd_r2_hi",     RD,    16'h0014, 32'h0,         4'hf, 1, 32'hA5A5_A5A5, 0);
    add_entry("part_wr",      WR_NP, 16'h0008, 32'hDEAD_BEEF, 4'h5, 1, 32'h0000_0000, 0);
    add_entry("rd_part",      RD,    16'h0008, 32'h0,         4'hf, 1, 32'h11AD_22EF, 0);
    add_entry("rd_part_hi",   RD,    16'h000C, 32'h0,         4'hf, 1, 32'h3333_4444, 0);
    add_entry("post_wr_lo",   WR,    16'h0018, 32'hCAFE_F00D, 4'hf, 0, 32'h0000_0000, 0);
    add_entry("post_wr_hi",   WR,    16'h001C, 32'h0BAD_CAFE, 4'hc, 0, 32'h0000_0000, 0);
    add_entry("rd_post_lo",   RD,    16'h0018, 32'h0,         4'hf, 1, 32'hCAFE_F00D, 0);
    add_entry("rd_post_hi",   RD,    16'h001C, 32'h0,         4'hf, 1, 32'h0BAD_0000, 0);
    add_entry("rd_id_lo",     RD,    16'h0038, 32'h0,         4'hf, 1, 32'h0000_0064, 0);
    add_entry("rd_id_hi",     RD,    16'h003C, 32'h0,         4'hf, 1, 32'hC5A0_0001, 0);
    add_entry("wr_id",        WR_NP, 16'h003C, 32'hFFFF_FFFF, 4'hf, 1, 32'h0000_0000, 0);
    add_entry("rd_id_after",  RD,    16'h003C, 32'h0,         4'hf, 1, 32'hC5A0_0001, 0);
    add_entry("rd_oob",       RD,    16'h0040, 32'h0,         4'hf, 1, 32'h0000_0000, 1);
    add_entry("wr_oob",       WR_NP, 16'h0048, 32'h1234_5678, 4'hf, 1, 32'h0000_0000, 1);
    add_entry("rd_oob_far",   RD,    16'h0104, 32'h0,         4'hf, 1, 32'h0000_0000, 1);
    add_entry("rd_after_oob", RD,    16'h0008, 32'h0,         4'hf, 1, 32'h11AD_22EF, 0);

    for (int i = 0; i < ENTRY_COUNT; i++) begin
      if (vectors[i].has_resp) begin
        expected_resps++;
      end
    end

    @(posedge rst_n);
    @(negedge clk);
    check_value("accept after reset", 1'b1, cmd_accept);
    @(posedge clk);
    #1;
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      apply_entry(vectors[i]);
    end
    check_value("response count", expected_resps, resp_count);

    $display("Errors: %0d, responses seen: %0d of %0d", error_count, resp_count,
             expected_resps);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== bench/csr_upsize_assertions.sv ====
// Protocol assertions for the CSR upsizer top level.
// Command and response hold rules, one outstanding non-posted
// command, and an idle response right after reset.
module csr_upsize_assertions (
  input logic                        i_clk,
  input logic                        i_rst_n,
  input logic                        i_cmd_valid,
  input logic                        i_cmd_accept,
  input csr_bus_pkg::csr_cmd_t       i_cmd,
  input csr_bus_pkg::csr_addr_t      i_addr,
  input csr_bus_pkg::narrow_data_t   i_data,
  input csr_bus_pkg::narrow_byteen_t i_byteen,
  input logic                        i_resp_valid,
  input logic                        i_resp_accept,
  input csr_bus_pkg::narrow_data_t   i_resp_data,
  input logic                        i_resp_error
);

  logic cmd_fire;
  logic resp_fire;
  logic non_posted;
  logic outstanding;

  assign cmd_fire   = i_cmd_valid && i_cmd_accept;
  assign resp_fire  = i_resp_valid && i_resp_accept;
  assign non_posted = i_cmd != csr_bus_pkg::CSR_WRITE;

  // Set by an accepted read or non-posted write.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outstanding <= 1'b0;
    end else if (resp_fire) begin
      outstanding <= 1'b0;
    end else if (cmd_fire && non_posted) begin
      outstanding <= 1'b1;
    end
  end

  cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_cmd_valid && !i_cmd_accept |=>
      i_cmd_valid && $stable({i_cmd, i_addr, i_data, i_byteen}))
    else $error("Command dropped or changed before it was accepted");

  resp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_resp_valid && !i_resp_accept |=>
      i_resp_valid && $stable({i_resp_data, i_resp_error}))
    else $error("Response dropped or changed before it was accepted");

  single_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    cmd_fire |-> !outstanding)
    else $error("Command accepted while a response was still due");

  idle_after_reset: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> !i_resp_valid)
    else $error("Response valid high right after reset");

endmodule

bind csr_upsize_top csr_upsize_assertions u_assertions (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_cmd_valid   (i_cmd_valid),
  .i_cmd_accept  (o_cmd_accept),
  .i_cmd         (i_cmd),
  .i_addr        (i_addr),
  .i_data        (i_data),
  .i_byteen      (i_byteen),
  .i_resp_valid  (o_resp_valid),
  .i_resp_accept (i_resp_accept),
  .i_resp_data   (o_resp_data),
  .i_resp_error  (o_resp_error)
);

// ==== bench/tb_clock.sv ====
// Clock and reset source for the testbench.
// 20 unit clock period, active low reset held for two cycles.
module tb_clock (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 2;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_rst_n = 1'b1;   // Released just after an edge.
  end

endmodule

// ==== src/csr_upsize_top.sv ====
// Top level of the CSR upsizer subsystem.
// Narrow command and response ports, the upsizer and the wide
// side decode, register bank and response stages.
module csr_upsize_top (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_cmd_valid,
  output logic                        o_cmd_accept,
  input  csr_bus_pkg::csr_cmd_t       i_cmd,
  input  csr_bus_pkg::csr_addr_t      i_addr,
  input  csr_bus_pkg::narrow_data_t   i_data,
  input  csr_bus_pkg::narrow_byteen_t i_byteen,
  output logic                        o_resp_valid,
  input  logic                        i_resp_accept,
  output csr_bus_pkg::narrow_data_t   o_resp_data,
  output logic                        o_resp_error
);

  csr_wide_if wide_if ();

  csr_map_pkg::reg_index_t reg_index;
  logic                    range_error;
  logic                    read_only;
  logic                    cmd_fire;
  csr_bus_pkg::wide_data_t read_data;

  csr_upsizer u_upsizer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cmd_valid   (i_cmd_valid),
    .o_cmd_accept  (o_cmd_accept),
    .i_cmd         (i_cmd),
    .i_addr        (i_addr),
    .i_data        (i_data),
    .i_byteen      (i_byteen),
    .o_resp_valid  (o_resp_valid),
    .i_resp_accept (i_resp_accept),
    .o_resp_data   (o_resp_data),
    .o_resp_error  (o_resp_error),
    .wide_if       (wide_if.master)
  );

  csr_decode u_decode (
    .wide_if       (wide_if.monitor),
    .o_reg_index   (reg_index),
    .o_range_error (range_error),
    .o_read_only   (read_only)
  );

  csr_reg_bank u_reg_bank (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .wide_if       (wide_if.monitor),
    .i_reg_index   (reg_index),
    .i_range_error (range_error),
    .i_read_only   (read_only),
    .i_cmd_fire    (cmd_fire),
    .o_read_data   (read_data)
  );

  csr_resp u_resp (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .wide_if       (wide_if.slave),
    .i_read_data   (read_data),
    .i_range_error (range_error),
    .o_cmd_fire    (cmd_fire)
  );

endmodule

// ==== src/csr_resp.sv ====
// Wide side response register.
// Command accept from occupancy, the command fire strobe,
// and a held response for reads and non-posted writes.
module csr_resp (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  csr_wide_if.slave               wide_if,
  input  csr_bus_pkg::wide_data_t i_read_data,
  input  logic                    i_range_error,
  output logic                    o_cmd_fire
);

  logic                    resp_valid_q;
  csr_bus_pkg::wide_data_t resp_data_q;
  logic                    resp_error_q;
  logic                    resp_fire;
  logic                    resp_load;

  assign resp_fire = resp_valid_q && wide_if.mresp_accept;

  // Free slot, or the slot empties this cycle.
  assign wide_if.scmd_accept = !resp_valid_q || resp_fire;
  assign o_cmd_fire          = wide_if.mcmd_valid && wide_if.scmd_accept;

  // Posted writes leave no response.
  assign resp_load = o_cmd_fire
                  && (wide_if.mcmd inside {csr_bus_pkg::CSR_READ, csr_bus_pkg::CSR_WRITE_NP});

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      resp_valid_q <= 1'b0;
    end else if (resp_load) begin
      resp_valid_q <= 1'b1;
    end else if (resp_fire) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (resp_load) begin
      resp_error_q <= i_range_error;
      // Read data only for a good read.
      resp_data_q  <= (wide_if.mcmd == csr_bus_pkg::CSR_READ && !i_range_error) ? i_read_data
                    : '0;
    end
  end

  assign wide_if.sresp_valid = resp_valid_q;
  assign wide_if.sresp_data  = resp_data_q;
  assign wide_if.sresp_error = resp_error_q;

endmodule

// ==== src/csr_reg_bank.sv ====
// CSR register storage.
// Registers 0 to 6 with byte-masked writes, the fixed identity
// value at index 7, combinational read data.
module csr_reg_bank (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  csr_wide_if.monitor             wide_if,
  input  csr_map_pkg::reg_index_t i_reg_index,
  input  logic                    i_range_error,
  input  logic                    i_read_only,
  input  logic                    i_cmd_fire,
  output csr_bus_pkg::wide_data_t o_read_data
);

  localparam int RW_COUNT = csr_map_pkg::REG_COUNT - 1;   // All but the identity register.

  csr_bus_pkg::wide_data_t regs_q [RW_COUNT];
  logic                    write_en;

  // Both write flavours update, illegal targets are dropped.
  assign write_en = i_cmd_fire
                 && (wide_if.mcmd inside {csr_bus_pkg::CSR_WRITE, csr_bus_pkg::CSR_WRITE_NP})
                 && !i_range_error
                 && !i_read_only;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int r = 0; r < RW_COUNT; r++) begin
        regs_q[r] <= csr_map_pkg::REG_RESET_VALUE;
      end
    end else if (write_en) begin
      for (int b = 0; b < csr_bus_pkg::WIDE_BYTES; b++) begin
        if (wide_if.mdata_byteen[b]) begin
          regs_q[i_reg_index][8*b +: 8] <= wide_if.mdata[8*b +: 8];
        end
      end
    end
  end

  // Value before any write at this edge.
  always_comb begin
    if (i_read_only) begin
      o_read_data = csr_map_pkg::ID_VALUE;
    end else begin
      o_read_data = regs_q[i_reg_index];
    end
  end

endmodule

// ==== src/csr_decode.sv ====
// Address decode for the wide CSR command.
// Register index, out-of-map error and read-only flag.
module csr_decode (
  csr_wide_if.monitor           wide_if,
  output csr_map_pkg::reg_index_t o_reg_index,
  output logic                    o_range_error,
  output logic                    o_read_only
);

  csr_map_pkg::reg_index_t reg_index;

  // Index comes from the 8-byte register slot.
  assign reg_index =
    wide_if.maddr[csr_map_pkg::REG_INDEX_LSB +: csr_map_pkg::REG_INDEX_WIDTH];

  assign o_reg_index   = reg_index;
  assign o_range_error = wide_if.maddr >= csr_map_pkg::MAP_LIMIT;   // Past the last register.

  // The identity register ignores writes.
  assign o_read_only = reg_index == csr_map_pkg::ID_REG_INDEX;

endmodule

// ==== src/csr_upsizer.sv ====
// Narrow to wide CSR upsizer.
// Replicates write data into both lanes, steers byte enables,
// keeps one non-posted command outstanding and picks the response lane.
module csr_upsizer (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_cmd_valid,
  output logic                        o_cmd_accept,
  input  csr_bus_pkg::csr_cmd_t       i_cmd,
  input  csr_bus_pkg::csr_addr_t      i_addr,
  input  csr_bus_pkg::narrow_data_t   i_data,
  input  csr_bus_pkg::narrow_byteen_t i_byteen,
  output logic                        o_resp_valid,
  input  logic                        i_resp_accept,
  output csr_bus_pkg::narrow_data_t   o_resp_data,
  output logic                        o_resp_error,
  csr_wide_if.master                  wide_if
);

  logic                     wait_for_response;
  csr_bus_pkg::word_index_t word_index;
  csr_bus_pkg::word_index_t word_index_q;   // Lane of the outstanding command.
  logic                     cmd_fire;
  logic                     cmd_non_posted;
  logic                     resp_fire;

  assign cmd_fire       = i_cmd_valid && o_cmd_accept;
  assign cmd_non_posted = i_cmd inside {csr_bus_pkg::CSR_READ, csr_bus_pkg::CSR_WRITE_NP};
  assign resp_fire      = o_resp_valid && i_resp_accept;

  // Live lane for a new command, stored lane while a response is due.
  assign word_index = wait_for_response ? word_index_q
                    : i_addr[csr_bus_pkg::WORD_INDEX_LSB +: csr_bus_pkg::WORD_INDEX_WIDTH];

  always_ff @(posedge i_clk) begin
    if (cmd_fire && cmd_non_posted) begin
      word_index_q <= word_index;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wait_for_response <= 1'b0;
    end else if (resp_fire) begin
      wait_for_response <= 1'b0;
    end else if (cmd_fire && cmd_non_posted) begin
      wait_for_response <= 1'b1;
    end
  end

  // Command path, blocked while a response is outstanding.
  assign o_cmd_accept       = !wait_for_response && wide_if.scmd_accept;
  assign wide_if.mcmd_valid = !wait_for_response && i_cmd_valid;
  assign wide_if.mcmd       = i_cmd;
  assign wide_if.maddr      = i_addr;
  assign wide_if.mdata      = {csr_bus_pkg::LANE_COUNT{i_data}};   // Same word in every lane.

  always_comb begin
    wide_if.mdata_byteen = '0;
    wide_if.mdata_byteen[csr_bus_pkg::NARROW_BYTES*word_index +: csr_bus_pkg::NARROW_BYTES] =
      i_byteen;
  end

  // Single-beat commands.
  assign wide_if.mlength     = '0;
  assign wide_if.mdata_valid = 1'b0;
  assign wide_if.mdata_last  = 1'b0;

  // Response path, open only for the command we are waiting on.
  assign wide_if.mresp_accept = wait_for_response && i_resp_accept;
  assign o_resp_valid         = wait_for_response && wide_if.sresp_valid;
  assign o_resp_error         = wide_if.sresp_error;
  assign o_resp_data          =
    wide_if.sresp_data[csr_bus_pkg::NARROW_WIDTH*word_index +: csr_bus_pkg::NARROW_WIDTH];

endmodule

// ==== src/csr_wide_if.sv ====
// Wide CSR command and response interface.
// Modports for the master side, the slave side and a command monitor.
interface csr_wide_if;

  // Command half.
  logic                       mcmd_valid;
  csr_bus_pkg::csr_cmd_t      mcmd;
  csr_bus_pkg::csr_addr_t     maddr;
  csr_bus_pkg::wide_data_t    mdata;
  csr_bus_pkg::wide_byteen_t  mdata_byteen;
  logic [3:0]                 mlength;      // Single beat only, tied to zero.
  logic                       mdata_valid;
  logic                       mdata_last;
  logic                       scmd_accept;

  // Response half.
  logic                       sresp_valid;
  csr_bus_pkg::wide_data_t    sresp_data;
  logic                       sresp_error;
  logic                       mresp_accept;

  modport master (
    output mcmd_valid, mcmd, maddr, mdata, mdata_byteen,
    output mlength, mdata_valid, mdata_last, mresp_accept,
    input  scmd_accept, sresp_valid, sresp_data, sresp_error
  );

  modport slave (
    input  mcmd_valid, mcmd, maddr, mdata, mdata_byteen,
    input  mlength, mdata_valid, mdata_last, mresp_accept,
    output scmd_accept, sresp_valid, sresp_data, sresp_error
  );

  modport monitor (
    input mcmd_valid, mcmd, maddr, mdata, mdata_byteen, mlength, mdata_valid, mdata_last
  );

endinterface

// ==== src/csr_map_pkg.sv ====
// Register map of the CSR bank.
// Register count and index type, address limit of the map,
// the identity register and the reset value of the others.
package csr_map_pkg;

  localparam int REG_COUNT       = 8;
  localparam int REG_INDEX_WIDTH = $clog2(REG_COUNT);
  localparam int REG_INDEX_LSB   = 3;   // One 64-bit register per 8 bytes.

  // Register index, address bits 5 to 3.
  typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;

  // First byte address past the last register.
  localparam csr_bus_pkg::csr_addr_t MAP_LIMIT = 16'h0040;

  // Read-only identity register.
  localparam reg_index_t ID_REG_INDEX = 3'd7;
  localparam csr_bus_pkg::wide_data_t ID_VALUE = 64'hC5A0_0001_0000_0064;

  localparam csr_bus_pkg::wide_data_t REG_RESET_VALUE = '0;

endpackage

// ==== src/csr_bus_pkg.sv ====
// Bus level definitions for the CSR upsizer.
// Narrow and wide data widths, byte enable and address types,
// the derived lane constants and the command encoding.
package csr_bus_pkg;

  localparam int NARROW_WIDTH   = 32;
  localparam int WIDE_WIDTH     = 64;
  localparam int ADDR_WIDTH     = 16;
  localparam int WORD_INDEX_LSB = 2;   // First address bit above the narrow word.

  // Lane geometry, derived from the two widths.
  localparam int NARROW_BYTES     = NARROW_WIDTH / 8;
  localparam int WIDE_BYTES       = WIDE_WIDTH / 8;
  localparam int LANE_COUNT       = WIDE_WIDTH / NARROW_WIDTH;
  localparam int WORD_INDEX_WIDTH = $clog2(LANE_COUNT);

  typedef logic [NARROW_WIDTH-1:0]     narrow_data_t;
  typedef logic [WIDE_WIDTH-1:0]       wide_data_t;
  typedef logic [NARROW_BYTES-1:0]     narrow_byteen_t;
  typedef logic [WIDE_BYTES-1:0]       wide_byteen_t;
  typedef logic [ADDR_WIDTH-1:0]       csr_addr_t;
  typedef logic [WORD_INDEX_WIDTH-1:0] word_index_t;

  typedef enum logic [1:0] {
    CSR_READ     = 2'd0,
    CSR_WRITE    = 2'd1,   // Posted, no response.
    CSR_WRITE_NP = 2'd2    // Non-posted, answered with a response.
  } csr_cmd_t;

endpackage
